// ==== Makefile ====
SIM      = verilator
TOP      = tia_video_tb
FILELIST = verilog.f
FLAGS    = --binary --timing --assert
RUNARGS  = +verilator+error+limit+100
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	rm -f $(LOG)
	-./$(OBJDIR)/V$(TOP) $(RUNARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/tia_video_checker.sv ====
// tia video assertions
`timescale 1ns/1ps
`default_nettype none

`include "tia_config.svh"

module tia_video_checker (
  input logic       CCLK,
  input logic       reset,
  input logic       rdy,
  input logic       hsync,
  input logic       hblank,
  input logic [2:0] lum,
  input logic [3:0] col
);

  int fail_cnt = 0;  // failed assertions so far
  int low_run;       // consecutive cycles with rdy low

  always_ff @(posedge CCLK) begin
    if (reset) low_run <= 0;
    else if (!rdy) low_run <= low_run + 1;
    else low_run <= 0;
  end

  // sync only inside blank
  a_sync_in_blank: assert property (@(posedge CCLK) disable iff (reset) hsync |-> hblank)
    else begin fail_cnt++; $error("hsync high outside hblank"); end

  a_blank_black: assert property (@(posedge CCLK) disable iff (reset)
                                  hblank |-> (lum == 3'd0 && col == 4'd0))
    else begin fail_cnt++; $error("colour output during hblank"); end

  a_rdy_after_reset: assert property (@(posedge CCLK) reset |=> rdy)
    else begin fail_cnt++; $error("rdy low right after reset"); end

  // stall never exceeds one line
  a_stall_bound: assert property (@(posedge CCLK) disable iff (reset)
                                  low_run <= `TIA_LINE_CLOCKS)
    else begin fail_cnt++; $error("rdy low for more than one line"); end

endmodule

bind tia_video tia_video_checker u_checker (
  .CCLK(CCLK), .reset(reset), .rdy(rdy), .hsync(hsync), .hblank(hblank),
  .lum(lum), .col(col)
);

`default_nettype wire

// ==== dv/tia_video_tb.sv ====
// tia video testbench
`timescale 1ns/1ps
`default_nettype none

`include "tia_config.svh"

module tia_video_tb import tia_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 4;
  localparam int WATCHDOG_CYCLES = 30 * `TIA_LINE_CLOCKS + RESET_CYCLES;

  logic       CCLK = 1'b0;
  logic       reset;
  logic [3:0] cs;
  logic       r_w;
  logic [5:0] a;
  logic [7:0] d_in;
  logic       rdy;
  logic       hsync;
  logic       hblank;
  logic       vsync;
  logic       vblank;
  logic [2:0] lum;
  logic [3:0] col;

  int          cyc = 0;              // rising edges since start
  int          wr_cyc;               // sampling edge of last bus write
  logic [31:0] rng = 32'd99838;
  logic        line_req = 1'b0;      // hands one line to the compare process
  string       line_name;
  logic [7:0]  m_pf0, m_pf1, m_pf2, m_ctrl;  // register model
  color_lum_t  m_colup0, m_colup1, m_colupf, m_colubk;
  logic        m_vsync, m_vblank;

  tia_video u_tia_video (
    .CCLK(CCLK), .reset(reset), .cs(cs), .r_w(r_w), .a(a), .d_in(d_in),
    .rdy(rdy), .hsync(hsync), .hblank(hblank), .vsync(vsync), .vblank(vblank),
    .lum(lum), .col(col)
  );

  initial begin
    forever #(CLK_PERIOD / 2) CCLK = ~CCLK;
  end

  always @(posedge CCLK) cyc <= cyc + 1;

  function automatic logic [7:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng[7:0];
  endfunction

  // playfield group in display order from the raw bytes
  function automatic logic pf_group(input int idx);
    if (idx < 4) return m_pf0[3'(4 + idx)];   // pf0 upper nibble
    if (idx < 12) return m_pf1[3'(11 - idx)]; // pf1 msb first
    return m_pf2[3'(idx - 12)];               // pf2 lsb first
  endfunction

  // expected colour of visible pixel p with bit 0 zero
  function automatic color_lum_t expected_color(input int p);
    int g;
    int idx;
    color_lum_t c;
    g = p / 4;
    if (g < `TIA_PF_HALF) idx = g;
    else if (m_ctrl[0]) idx = 2 * `TIA_PF_HALF - 1 - g;  // mirrored half
    else idx = g - `TIA_PF_HALF;
    if (!pf_group(idx)) c = m_colubk;
    else if (m_ctrl[1]) c = (g >= `TIA_PF_HALF) ? m_colup1 : m_colup0;
    else c = m_colupf;
    return {c[7:1], 1'b0};
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pixel(input string name, input color_lum_t exp, input color_lum_t act);
    if (exp !== act) fail_stop($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_count(input string name, input hcount_t exp, input hcount_t act);
    if (exp !== act) fail_stop($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) fail_stop($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  // one bus cycle ending at the falling edge after the sampling edge
  task automatic bus_cycle(input logic [3:0] sel, input logic rw, input tia_waddr_e addr,
                           input logic [7:0] data);
    @(posedge CCLK);
    cs   <= sel;
    r_w  <= rw;
    a    <= addr;
    d_in <= data;
    @(posedge CCLK);
    cs   <= 4'b0000;
    r_w  <= 1'b1;
    @(negedge CCLK);
    wr_cyc = cyc;
  endtask

  task automatic write_reg(input tia_waddr_e addr, input logic [7:0] data);
    bus_cycle(4'b0001, 1'b0, addr, data);
    case (addr)
      waddr_vsync:  m_vsync = data[1];
      waddr_vblank: m_vblank = data[1];
      waddr_colup0: m_colup0 = data;
      waddr_colup1: m_colup1 = data;
      waddr_colupf: m_colupf = data;
      waddr_colubk: m_colubk = data;
      waddr_ctrlpf: m_ctrl = data;
      waddr_pf0:    m_pf0 = data;
      waddr_pf1:    m_pf1 = data;
      waddr_pf2:    m_pf2 = data;
      default: ;  // strobes hold no state
    endcase
  endtask

  task automatic wait_hsync_rise(output int at);
    @(negedge CCLK);
    while (hsync) @(negedge CCLK);
    while (!hsync) @(negedge CCLK);
    at = cyc;
  endtask

  task automatic wait_hblank_fall();
    @(negedge CCLK);
    while (!hblank) @(negedge CCLK);
    while (hblank) @(negedge CCLK);
  endtask

  // whole line from the hsync rise with blanked offsets black
  task automatic check_line(input string name);
    int rise;
    color_lum_t exp;
    wait_hsync_rise(rise);
    for (int k = 0; k < `TIA_LINE_CLOCKS; k++) begin
      if (k > 0) @(negedge CCLK);
      exp = (k >= 48 && k < 208) ? expected_color(k - 48) : '0;
      check_pixel($sformatf("%s offset %0d", name, k), exp, {col, lum, 1'b0});
    end
  endtask

  initial begin : compare_lines
    forever begin
      wait (line_req);
      check_line(line_name);
      line_req = 1'b0;
    end
  end

  task automatic run_line_check(input string name);
    line_name = name;
    line_req = 1'b1;
    wait (!line_req);
  endtask

  task automatic check_timing();
    int r0;
    int r1;
    int width;
    wait_hsync_rise(r0);
    width = 0;
    while (hsync) begin
      width++;
      @(negedge CCLK);
    end
    while (hblank) @(negedge CCLK);
    check_count("hblank fall after hsync", hcount_t'(48), hcount_t'(cyc - r0));
    wait_hsync_rise(r1);
    check_count("hsync width", hcount_t'(16), hcount_t'(width));
    check_count("line period", hcount_t'(`TIA_LINE_CLOCKS), hcount_t'(r1 - r0));
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_stop("watchdog expired before the tests finished");
  end

  // first failed assertion in the bound checker ends the run
  always @(u_tia_video.u_checker.fail_cnt) begin
    if (u_tia_video.u_checker.fail_cnt != 0) fail_stop("an assertion in the checker failed");
  end

  initial begin : main
    int h;
    int stall;
    reset = 1'b1;
    cs = 4'b0000;
    r_w = 1'b1;
    a = '0;
    d_in = '0;
    {m_pf0, m_pf1, m_pf2, m_ctrl, m_vsync, m_vblank} = '0;
    {m_colup0, m_colup1, m_colupf, m_colubk} = '0;
    repeat (RESET_CYCLES) @(posedge CCLK);
    reset <= 1'b0;
    @(negedge CCLK);
    check_flag("rdy after reset", 1'b1, rdy);
    check_flag("vsync after reset", 1'b0, vsync);
    check_flag("vblank after reset", 1'b0, vblank);
    check_flag("hsync after reset", 1'b0, hsync);
    check_flag("hblank after reset", 1'b0, hblank);
    check_pixel("colour after reset", '0, {col, lum, 1'b0});

    check_timing();

    write_reg(waddr_colubk, next_rand());
    run_line_check("background");

    write_reg(waddr_pf0, next_rand());
    write_reg(waddr_pf1, next_rand());
    write_reg(waddr_pf2, next_rand());
    write_reg(waddr_colupf, next_rand());
    run_line_check("repeat playfield");

    for (int mode = 1; mode < 4; mode++) begin
      write_reg(waddr_colup0, next_rand());
      write_reg(waddr_colup1, next_rand());
      write_reg(waddr_colupf, next_rand());
      write_reg(waddr_colubk, next_rand());
      write_reg(waddr_ctrlpf, 8'(mode));  // bit 0 reflect, bit 1 score
      run_line_check($sformatf("ctrlpf mode %0d", mode));
    end

    write_reg(waddr_vsync, 8'h02);
    check_flag("vsync set", 1'b1, vsync);
    write_reg(waddr_vblank, 8'h02);
    check_flag("vblank set", 1'b1, vblank);
    write_reg(waddr_vsync, 8'h00);
    check_flag("vsync clear", 1'b0, vsync);
    bus_cycle(4'b0011, 1'b0, waddr_vblank, 8'h00);    // wrong chip select
    bus_cycle(4'b0001, 1'b1, waddr_colubk, ~m_colubk); // read cycle
    bus_cycle(4'b0000, 1'b0, waddr_pf1, ~m_pf1);
    check_flag("vblank after ignored write", 1'b1, vblank);
    write_reg(waddr_vblank, 8'h00);
    check_flag("vblank clear", 1'b0, vblank);
    run_line_check("ignored writes");

    wait_hblank_fall();  // no stale sync in the pipe
    write_reg(waddr_rsync, 8'h00);
    wait_hsync_rise(h);
    check_count("rsync to hsync", hcount_t'(22), hcount_t'(h - wr_cyc));

    wait_hblank_fall();
    write_reg(waddr_wsync, 8'h00);
    check_flag("rdy after wsync", 1'b0, rdy);
    stall = 0;
    while (!rdy) begin
      @(negedge CCLK);
      stall++;
    end
    if (stall > `TIA_LINE_CLOCKS) fail_stop("rdy stayed low longer than one line after wsync");
    stall = cyc;
    wait_hsync_rise(h);
    check_count("rdy release to hsync", hcount_t'(21), hcount_t'(h - stall));

    if (u_tia_video.u_checker.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      fail_stop("an assertion in the checker failed");
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/tia_pkg.sv
verilog/tia_regs.sv
verilog/tia_beam.sv
verilog/tia_playfield.sv
verilog/tia_color.sv
verilog/tia_video.sv
dv/tia_video_checker.sv
dv/tia_video_tb.sv

// ==== verilog/tia_beam.sv ====
// tia beam counter stage
`timescale 1ns/1ps
`default_nettype none

`include "tia_config.svh"

module tia_beam import tia_pkg::*; (
  input  logic    CCLK,
  input  logic    reset,
  input  logic    wsync_cmd,
  input  logic    rsync_cmd,
  output hcount_t hcount,
  output logic    rdy
);

  logic wsync_q;  // processor held while set

  // horizontal count, 0 .. line length - 1
  always_ff @(posedge CCLK) begin
    if (reset) begin
      hcount <= '0;
    end else if (rsync_cmd) begin
      hcount <= '0;  // restart line from sync strobe
    end else if (hcount == hcount_t'(`TIA_LINE_CLOCKS - 1)) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + hcount_t'(1);
    end
  end

  // wait for sync latch
  // set wins over clear, so a write at count 0 holds a full line
  always_ff @(posedge CCLK) begin
    if (reset) begin
      wsync_q <= 1'b0;
    end else if (wsync_cmd) begin
      wsync_q <= 1'b1;
    end else if (hcount == '0) begin
      wsync_q <= 1'b0;  // start of line releases the cpu
    end
  end

  assign rdy = !wsync_q;

endmodule

`default_nettype wire

// ==== verilog/tia_color.sv ====
// tia colour output stage
`timescale 1ns/1ps
`default_nettype none

module tia_color import tia_pkg::*; (
  input  logic       CCLK,
  input  logic       reset,
  input  logic       pf_dot,
  input  logic       right_half,
  input  logic       hsync_s,
  input  logic       hblank_s,
  input  logic       score_mode,
  input  color_lum_t colup0,
  input  color_lum_t colup1,
  input  color_lum_t colupf,
  input  color_lum_t colubk,
  output logic [2:0] lum,
  output logic [3:0] col,
  output logic       hsync,
  output logic       hblank
);

  color_lum_t pf_color;  // playfield colour after score mode
  color_lum_t pix_color;

  // score mode paints each half in its player colour
  always_comb begin
    if (score_mode) begin
      pf_color = right_half ? colup1 : colup0;
    end else begin
      pf_color = colupf;
    end
  end

  assign pix_color = pf_dot ? pf_color : colubk;

  always_ff @(posedge CCLK) begin
    if (reset) begin
      lum    <= '0;
      col    <= '0;
      hsync  <= 1'b0;
      hblank <= 1'b0;
    end else begin
      // black during blank, sync and blank delayed to match
      lum    <= hblank_s ? 3'b000 : pix_color[3:1];
      col    <= hblank_s ? 4'b0000 : pix_color[7:4];
      hsync  <= hsync_s;
      hblank <= hblank_s;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tia_config.svh ====
// tia line timing constants
`ifndef TIA_CONFIG_SVH
`define TIA_CONFIG_SVH

// one scan line in colour clocks, counter runs 0 .. 227
`define TIA_LINE_CLOCKS 228

// horizontal sync window, both ends inclusive
`define TIA_HSYNC_START 20
`define TIA_HSYNC_END   35   // 16 counts of sync

// counts below this are blanked, 160 visible pixels follow
`define TIA_HBLANK_END  68

// playfield groups of 4 pixels in one half line
// left half shows groups 0 .. 19 as stored
// right half repeats or mirrors them
`define TIA_PF_HALF     20

`endif

// ==== verilog/tia_pkg.sv ====
// tia video types
`default_nettype none

package tia_pkg;

  typedef logic [7:0]  hcount_t;     // beam count and visible pixel index
  typedef logic [7:0]  color_lum_t;  // hue [7:4], lum [3:1], bit 0 unused
  typedef logic [19:0] pf_bits_t;    // bit 0 = leftmost group

  // write addresses kept from the full register map
  typedef enum logic [5:0] {
    waddr_vsync  = 6'h00,
    waddr_vblank = 6'h01,
    waddr_wsync  = 6'h02,  // strobe only
    waddr_rsync  = 6'h03,  // strobe only
    waddr_colup0 = 6'h06,
    waddr_colup1 = 6'h07,
    waddr_colupf = 6'h08,
    waddr_colubk = 6'h09,
    waddr_ctrlpf = 6'h0a,
    waddr_pf0    = 6'h0d,
    waddr_pf1    = 6'h0e,
    waddr_pf2    = 6'h0f
  } tia_waddr_e;

endpackage

`default_nettype wire

// ==== verilog/tia_playfield.sv ====
// tia playfield lookup stage
`timescale 1ns/1ps
`default_nettype none

`include "tia_config.svh"

module tia_playfield import tia_pkg::*; (
  input  logic     CCLK,
  input  logic     reset,
  input  hcount_t  hcount,
  input  pf_bits_t pf,
  input  logic     pf_reflect,
  output logic     pf_dot,
  output logic     right_half,
  output logic     hsync_s,
  output logic     hblank_s
);

  logic       blank;
  logic       sync;
  hcount_t    pixel;   // visible pixel 0 .. 159
  logic [5:0] group;   // 4-pixel playfield group 0 .. 39
  logic       right;
  logic [5:0] pf_idx;  // bit of pf for this group

  assign blank = hcount < hcount_t'(`TIA_HBLANK_END);
  assign sync  = (hcount >= hcount_t'(`TIA_HSYNC_START)) &&
                 (hcount <= hcount_t'(`TIA_HSYNC_END));

  // pixel held at 0 in blank keeps the index in range
  assign pixel = blank ? '0 : hcount - hcount_t'(`TIA_HBLANK_END);
  assign group = pixel[7:2];
  assign right = group >= 6'(`TIA_PF_HALF);

  always_comb begin
    if (!right) begin
      pf_idx = group;
    end else if (pf_reflect) begin
      pf_idx = 6'(2 * `TIA_PF_HALF - 1) - group;  // mirrored
    end else begin
      pf_idx = group - 6'(`TIA_PF_HALF);          // repeated
    end
  end

  always_ff @(posedge CCLK) begin
    if (reset) begin
      pf_dot     <= 1'b0;
      right_half <= 1'b0;
      hsync_s    <= 1'b0;
      hblank_s   <= 1'b0;
    end else begin
      pf_dot     <= !blank && pf[pf_idx[4:0]];
      right_half <= right;
      hsync_s    <= sync;
      hblank_s   <= blank;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tia_regs.sv ====
// tia write register file
`timescale 1ns/1ps
`default_nettype none

module tia_regs import tia_pkg::*; (
  input  logic       CCLK,
  input  logic       reset,
  input  logic [3:0] cs,
  input  logic       r_w,
  input  logic [5:0] a,
  input  logic [7:0] d_in,
  output logic       wsync_cmd,   // one cycle, combinational
  output logic       rsync_cmd,   // one cycle, combinational
  output logic       vsync,
  output logic       vblank,
  output pf_bits_t   pf,
  output logic       pf_reflect,
  output logic       score_mode,
  output color_lum_t colup0,
  output color_lum_t colup1,
  output color_lum_t colupf,
  output color_lum_t colubk
);

  logic       wr_en;
  logic [3:0] pf0_r;  // only upper nibble of pf0 is displayed
  logic [7:0] pf1_r;
  logic [7:0] pf2_r;

  // chip selected and processor writing
  assign wr_en = (cs[1:0] == 2'b01) && !r_w;

  assign wsync_cmd = wr_en && (a == waddr_wsync);
  assign rsync_cmd = wr_en && (a == waddr_rsync);

  // display order, left to right
  // pf0 4..7, then pf1 7..0, then pf2 0..7
  assign pf = {pf2_r,
               pf1_r[0], pf1_r[1], pf1_r[2], pf1_r[3],
               pf1_r[4], pf1_r[5], pf1_r[6], pf1_r[7],
               pf0_r};

  always_ff @(posedge CCLK) begin
    if (reset) begin
      vsync      <= 1'b0;
      vblank     <= 1'b0;
      pf_reflect <= 1'b0;
      score_mode <= 1'b0;
      colup0     <= '0;
      colup1     <= '0;
      colupf     <= '0;
      colubk     <= '0;
      pf0_r      <= '0;
      pf1_r      <= '0;
      pf2_r      <= '0;
    end else if (wr_en) begin
      case (tia_waddr_e'(a))
        waddr_vsync:  vsync  <= d_in[1];
        waddr_vblank: vblank <= d_in[1];  // dump/latch bits ignored
        waddr_colup0: colup0 <= d_in;
        waddr_colup1: colup1 <= d_in;
        waddr_colupf: colupf <= d_in;
        waddr_colubk: colubk <= d_in;
        waddr_ctrlpf: begin
          pf_reflect <= d_in[0];  // mirror right half
          score_mode <= d_in[1];  // player colours on playfield
        end
        waddr_pf0: pf0_r <= d_in[7:4];
        waddr_pf1: pf1_r <= d_in;
        waddr_pf2: pf2_r <= d_in;
        default: ;  // wsync/rsync handled as strobes, others unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tia_video.sv ====
// tia video path top
`timescale 1ns/1ps
`default_nettype none

module tia_video import tia_pkg::*; (
  input  logic       CCLK,
  input  logic       reset,
  input  logic [3:0] cs,
  input  logic       r_w,
  input  logic [5:0] a,
  input  logic [7:0] d_in,
  output logic       rdy,
  output logic       hsync,
  output logic       hblank,
  output logic       vsync,
  output logic       vblank,
  output logic [2:0] lum,
  output logic [3:0] col
);

  logic       wsync_cmd;
  logic       rsync_cmd;
  pf_bits_t   pf;
  logic       pf_reflect;
  logic       score_mode;
  color_lum_t colup0;
  color_lum_t colup1;
  color_lum_t colupf;
  color_lum_t colubk;
  hcount_t    hcount;      // stage 1 -> 2
  logic       pf_dot;      // stage 2 -> 3
  logic       right_half;
  logic       hsync_s;
  logic       hblank_s;

  tia_regs u_regs (
    .CCLK(CCLK), .reset(reset), .cs(cs), .r_w(r_w), .a(a), .d_in(d_in),
    .wsync_cmd(wsync_cmd), .rsync_cmd(rsync_cmd), .vsync(vsync), .vblank(vblank),
    .pf(pf), .pf_reflect(pf_reflect), .score_mode(score_mode),
    .colup0(colup0), .colup1(colup1), .colupf(colupf), .colubk(colubk)
  );

  tia_beam u_beam (
    .CCLK(CCLK), .reset(reset), .wsync_cmd(wsync_cmd), .rsync_cmd(rsync_cmd),
    .hcount(hcount), .rdy(rdy)
  );

  tia_playfield u_playfield (
    .CCLK(CCLK), .reset(reset), .hcount(hcount), .pf(pf), .pf_reflect(pf_reflect),
    .pf_dot(pf_dot), .right_half(right_half), .hsync_s(hsync_s), .hblank_s(hblank_s)
  );

  tia_color u_color (
    .CCLK(CCLK), .reset(reset), .pf_dot(pf_dot), .right_half(right_half),
    .hsync_s(hsync_s), .hblank_s(hblank_s), .score_mode(score_mode),
    .colup0(colup0), .colup1(colup1), .colupf(colupf), .colubk(colubk),
    .lum(lum), .col(col), .hsync(hsync), .hblank(hblank)
  );

endmodule

`default_nettype wire
